//--- rt_scene_pkg.sv
// ################################################
// scene loader shared types: command codes, record
// structs, payload union and write request.
// ################################################

package rt_scene_pkg;

  // ################################################
  // command codes
  // ################################################
  typedef enum logic [7:0] {
    cam_origin  = 8'h00,
    cam_forward = 8'h01,
    cam_right   = 8'h02,
    cam_up      = 8'h03,
    obj_idx     = 8'h04,
    obj_data    = 8'h05,
    num_objs    = 8'h06,
    max_bounces = 8'h07,
    mat_idx     = 8'h08,
    mat_data    = 8'h09
  } cmd_e;

  localparam int MAX_PAYLOAD_BYTES = 9;

  // ################################################
  // scene records
  // ################################################
  typedef logic signed [15:0] fix16_t;  // 8.8 fixed point.

  typedef struct packed {
    fix16_t x;
    fix16_t y;
    fix16_t z;
  } vec3_t;

  typedef struct packed {
    vec3_t       center;
    fix16_t      radius;
    logic [7:0]  mat_idx;
  } object_t;

  typedef struct packed {
    logic [39:0] pad;  // unused upper bytes.
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic [7:0]  reflect;
  } material_t;

  // one payload word, seen as an object or a material.
  typedef union packed {
    object_t   obj;
    material_t mat;
  } payload_u;

  typedef struct packed {
    cmd_e     cmd;
    payload_u data;
  } scene_wr_t;

  typedef struct packed {
    vec3_t origin;
    vec3_t forward;
    vec3_t right;
    vec3_t up;
  } camera_t;

  function automatic logic [3:0] payload_len(cmd_e cmd);
    case (cmd)
      cam_origin, cam_forward, cam_right, cam_up: return 4'd6;
      obj_data: return 4'd9;
      mat_data: return 4'd4;
      default:  return 4'd1;
    endcase
  endfunction

  function automatic logic cmd_known(logic [7:0] code);
    return code <= 8'h09;  // codes are dense from zero.
  endfunction

endpackage

//--- uart_byte_rx.sv
// ################################################
// oversampled serial byte receiver, 8N1, lsb first.
// ################################################

`timescale 1ns/1ps

module uart_byte_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       rxd,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop,
    rx_wait
  } rx_state_t;

  rx_state_t        state;
  logic [1:0]       sync_q;
  logic             rxd_s;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;

  assign rxd_s = sync_q[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      sync_q   <= 2'b11;  // line idles high.
      state    <= rx_idle;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      sync_q   <= {sync_q[0], rxd};
      rx_valid <= 1'b0;
      case (state)
        rx_idle: begin
          cnt <= '0;
          if (!rxd_s) state <= rx_start;  // falling edge of start bit.
        end
        rx_start: begin
          if (cnt == HALF_CNT) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rxd_s ? rx_idle : rx_data;  // glitch check at mid bit.
          end else cnt <= cnt + 1'b1;
        end
        rx_data: begin
          if (cnt == FULL_CNT) begin
            cnt <= '0;
            if (bit_idx == 3'd7) state <= rx_stop;
            else bit_idx <= bit_idx + 1'b1;
          end else cnt <= cnt + 1'b1;
        end
        rx_stop: begin
          if (cnt == FULL_CNT) begin
            cnt <= '0;
            if (rxd_s) begin
              rx_valid <= 1'b1;
              state    <= rx_idle;
            end else state <= rx_wait;  // framing error, drop byte.
          end else cnt <= cnt + 1'b1;
        end
        default: if (rxd_s) state <= rx_idle;  // wait for idle line.
      endcase
    end
  end

  // data bits land at mid-bit, lsb first.
  always_ff @(posedge clk) begin
    if (state == rx_data && cnt == FULL_CNT) rx_byte <= {rxd_s, rx_byte[7:1]};
  end

  a_valid_pulse : assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid);

endmodule

//--- scene_cmd_parser.sv
// ################################################
// frame decoder: command byte plus payload bytes,
// msb first, into one scene write request.
// ################################################

`timescale 1ns/1ps

module scene_cmd_parser (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rx_valid,
  input  logic [7:0]            rx_byte,
  output logic                  busy,
  output logic                  wr_en,
  output rt_scene_pkg::scene_wr_t wr
);

  localparam int PAY_BITS = rt_scene_pkg::MAX_PAYLOAD_BYTES * 8;
  localparam int IDX_W    = $clog2(rt_scene_pkg::MAX_PAYLOAD_BYTES);

  typedef enum logic {
    st_idle,
    st_data
  } parse_state_t;

  parse_state_t     state;
  logic [IDX_W-1:0] byte_idx;
  logic [IDX_W-1:0] last_idx;
  logic             cmd_accept;
  logic             byte_accept;
  logic [PAY_BITS-1:0] payload_q;

  assign busy        = (state == st_data);
  assign cmd_accept  = (state == st_idle) && rx_valid && rt_scene_pkg::cmd_known(rx_byte);
  assign byte_accept = (state == st_data) && rx_valid;
  assign payload_q   = wr.data;

  // ################################################
  // frame FSM
  // ################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      byte_idx <= '0;
      last_idx <= '0;
      wr_en    <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (cmd_accept) begin
        byte_idx <= '0;
        last_idx <= IDX_W'(rt_scene_pkg::payload_len(rt_scene_pkg::cmd_e'(rx_byte)) - 4'd1);
        state    <= st_data;
      end else if (byte_accept) begin
        if (byte_idx == last_idx) begin
          byte_idx <= '0;
          wr_en    <= 1'b1;  // frame complete.
          state    <= st_idle;
        end else begin
          byte_idx <= byte_idx + 1'b1;
        end
      end
    end
  end

  // ################################################
  // request word
  // ################################################
  always_ff @(posedge clk) begin
    if (cmd_accept) begin
      wr.cmd  <= rt_scene_pkg::cmd_e'(rx_byte);
      wr.data <= '0;  // short payloads keep zero upper bytes.
    end else if (byte_accept) begin
      wr.data <= rt_scene_pkg::payload_u'({payload_q[PAY_BITS-9:0], rx_byte});
    end
  end

  a_wr_from_data : assert property (@(posedge clk) disable iff (rst)
    wr_en |-> $past(state == st_data));

  a_idx_bound : assert property (@(posedge clk) disable iff (rst) byte_idx <= last_idx);

endmodule

//--- scene_store.sv
// ################################################
// scene state: camera, pointers, counts and the
// object and material memories.
// ################################################

`timescale 1ns/1ps

module scene_store #(
  parameter int OBJ_IDX_WIDTH = 4,
  parameter int MAT_IDX_WIDTH = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wr_en,
  input  rt_scene_pkg::scene_wr_t wr,
  output rt_scene_pkg::camera_t   camera,
  output logic [OBJ_IDX_WIDTH-1:0] obj_ptr,
  output logic [MAT_IDX_WIDTH-1:0] mat_ptr,
  output logic [7:0]              num_objs,
  output logic [7:0]              max_bounces,
  output rt_scene_pkg::object_t   obj_mem [2**OBJ_IDX_WIDTH],
  output rt_scene_pkg::material_t mat_mem [2**MAT_IDX_WIDTH],
  output logic [2**OBJ_IDX_WIDTH-1:0] obj_written
);

  localparam int OBJ_DEPTH = 2**OBJ_IDX_WIDTH;
  localparam int MAT_DEPTH = 2**MAT_IDX_WIDTH;

  logic [$bits(rt_scene_pkg::payload_u)-1:0] pay;  // raw payload bits.
  rt_scene_pkg::vec3_t                       pay_vec;

  assign pay     = wr.data;
  assign pay_vec = pay[47:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      camera      <= '0;
      obj_ptr     <= '0;
      mat_ptr     <= '0;
      num_objs    <= '0;
      max_bounces <= '0;
      obj_written <= '0;
      for (int i = 0; i < OBJ_DEPTH; i++) begin
        obj_mem[i] <= '0;
      end
      for (int i = 0; i < MAT_DEPTH; i++) begin
        mat_mem[i] <= '0;
      end
    end else if (wr_en) begin
      case (wr.cmd)
        // ################################################
        // camera vectors
        // ################################################
        rt_scene_pkg::cam_origin:  camera.origin  <= pay_vec;
        rt_scene_pkg::cam_forward: camera.forward <= pay_vec;
        rt_scene_pkg::cam_right:   camera.right   <= pay_vec;
        rt_scene_pkg::cam_up:      camera.up      <= pay_vec;

        // ################################################
        // objects and materials
        // ################################################
        rt_scene_pkg::obj_idx: obj_ptr <= pay[OBJ_IDX_WIDTH-1:0];
        rt_scene_pkg::obj_data: begin
          obj_mem[obj_ptr]     <= wr.data.obj;
          obj_written[obj_ptr] <= 1'b1;  // entry now valid.
        end
        rt_scene_pkg::mat_idx:  mat_ptr <= pay[MAT_IDX_WIDTH-1:0];
        rt_scene_pkg::mat_data: mat_mem[mat_ptr] <= wr.data.mat;

        // counts
        rt_scene_pkg::num_objs:    num_objs    <= pay[7:0];
        rt_scene_pkg::max_bounces: max_bounces <= pay[7:0];
        default: ;
      endcase
    end
  end

  a_known_cmd : assert property (@(posedge clk) disable iff (rst)
    wr_en |-> rt_scene_pkg::cmd_known(wr.cmd));

endmodule

//--- scene_output.sv
// ################################################
// registered object and material read ports, plus
// the scene-ready flag.
// ################################################

`timescale 1ns/1ps

module scene_output #(
  parameter int OBJ_IDX_WIDTH = 4,
  parameter int MAT_IDX_WIDTH = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  rt_scene_pkg::object_t   obj_mem [2**OBJ_IDX_WIDTH],
  input  rt_scene_pkg::material_t mat_mem [2**MAT_IDX_WIDTH],
  input  logic [2**OBJ_IDX_WIDTH-1:0] obj_written,
  input  logic [7:0]              num_objs,
  input  logic [OBJ_IDX_WIDTH-1:0] obj_rd_idx,
  input  logic [MAT_IDX_WIDTH-1:0] mat_rd_idx,
  output rt_scene_pkg::object_t   obj_rd_data,
  output rt_scene_pkg::material_t mat_rd_data,
  output logic                    scene_ready
);

  localparam int OBJ_DEPTH = 2**OBJ_IDX_WIDTH;

  logic [OBJ_DEPTH-1:0] need_mask;
  logic                 ready_d;

  // objects 0 .. num_objs-1 must all be loaded.
  always_comb begin
    for (int i = 0; i < OBJ_DEPTH; i++) begin
      need_mask[i] = (i < num_objs);
    end
    ready_d = (num_objs != 8'd0) && (num_objs <= OBJ_DEPTH) &&
              ((obj_written & need_mask) == need_mask);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      obj_rd_data <= '0;
      mat_rd_data <= '0;
      scene_ready <= 1'b0;
    end else begin
      obj_rd_data <= obj_mem[obj_rd_idx];
      mat_rd_data <= mat_mem[mat_rd_idx];
      scene_ready <= ready_d;
    end
  end

endmodule

//--- scene_loader_top.sv
// ################################################
// scene loader top: receiver, parser, store and
// read-out block.
// ################################################

`timescale 1ns/1ps

module scene_loader_top #(
  parameter int CLKS_PER_BIT  = 16,
  parameter int OBJ_IDX_WIDTH = 4,
  parameter int MAT_IDX_WIDTH = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rxd,
  input  logic [OBJ_IDX_WIDTH-1:0] obj_rd_idx,
  input  logic [MAT_IDX_WIDTH-1:0] mat_rd_idx,
  output rt_scene_pkg::camera_t    camera,
  output logic [7:0]               num_objs,
  output logic [7:0]               max_bounces,
  output rt_scene_pkg::object_t    obj_rd_data,
  output rt_scene_pkg::material_t  mat_rd_data,
  output logic                     scene_ready,
  output logic                     load_done,
  output logic                     busy
);

  localparam int OBJ_DEPTH = 2**OBJ_IDX_WIDTH;
  localparam int MAT_DEPTH = 2**MAT_IDX_WIDTH;

  logic                    rx_valid;
  logic [7:0]              rx_byte;
  rt_scene_pkg::scene_wr_t wr;
  rt_scene_pkg::object_t   obj_mem [OBJ_DEPTH];
  rt_scene_pkg::material_t mat_mem [MAT_DEPTH];
  logic [OBJ_DEPTH-1:0]    obj_written;

  uart_byte_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .clk, .rst, .rxd, .rx_valid, .rx_byte
  );

  // load_done marks the end of each frame.
  scene_cmd_parser u_parser (
    .clk, .rst, .rx_valid, .rx_byte, .busy, .wr_en(load_done), .wr
  );

  scene_store #(.OBJ_IDX_WIDTH(OBJ_IDX_WIDTH), .MAT_IDX_WIDTH(MAT_IDX_WIDTH)) u_store (
    .clk, .rst, .wr_en(load_done), .wr, .camera, .obj_ptr(), .mat_ptr(),
    .num_objs, .max_bounces, .obj_mem, .mat_mem, .obj_written
  );

  scene_output #(.OBJ_IDX_WIDTH(OBJ_IDX_WIDTH), .MAT_IDX_WIDTH(MAT_IDX_WIDTH)) u_out (
    .clk, .rst, .obj_mem, .mat_mem, .obj_written, .num_objs,
    .obj_rd_idx, .mat_rd_idx, .obj_rd_data, .mat_rd_data, .scene_ready
  );

endmodule

//--- tb_scene_loader.sv
// ################################################
// testbench for the scene loader: table of serial
// frames, a scene model and read-port checks.
// ################################################

`timescale 1ns/1ps

module tb_scene_loader;

  localparam int PERIOD     = 40;
  localparam int BIT_CLKS   = 4;
  localparam int NUM_FRAMES = 20;
  localparam int MAX_BYTES  = 11;

  logic clk, rst, rxd, scene_ready, load_done, busy;
  logic [3:0] obj_rd_idx, mat_rd_idx;
  logic [7:0] num_objs, max_bounces;
  rt_scene_pkg::camera_t   camera;
  rt_scene_pkg::object_t   obj_rd_data;
  rt_scene_pkg::material_t mat_rd_data;

  // stimulus table and expected frame results.
  string      frame_name  [NUM_FRAMES];
  int         frame_len   [NUM_FRAMES];
  logic [7:0] frame_bytes [NUM_FRAMES][MAX_BYTES];
  int         bad_pos     [NUM_FRAMES];
  int         exp_done    [NUM_FRAMES];
  logic       exp_ready   [NUM_FRAMES];
  int         nf = 0;
  logic [31:0] rng = 32'h4e049455;

  // scene model.
  rt_scene_pkg::camera_t   exp_cam;
  rt_scene_pkg::object_t   exp_obj [16];
  rt_scene_pkg::material_t exp_mat [16];
  logic [3:0]  m_obj_ptr, m_mat_ptr;
  logic [7:0]  exp_num, exp_bounce, m_cmd;
  logic [71:0] m_pay;
  logic        m_busy;
  int          m_left;
  int done_cnt = 0, check_count = 0, error_count = 0;

  scene_loader_top #(.CLKS_PER_BIT(BIT_CLKS), .OBJ_IDX_WIDTH(4), .MAT_IDX_WIDTH(4)) u_dut (
    .clk, .rst, .rxd, .obj_rd_idx, .mat_rd_idx, .camera, .num_objs, .max_bounces,
    .obj_rd_data, .mat_rd_data, .scene_ready, .load_done, .busy
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  always @(negedge clk) if (load_done) done_cnt++;  // end-of-frame pulses.

  initial begin
    #(NUM_FRAMES * MAX_BYTES * 40 * PERIOD * 2);
    $display("watchdog expired before all frames were checked");
    $display("*** FAILED ***");
    $finish;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic int cmd_bytes(input logic [7:0] code);
    if (code <= 8'h03) return 6;  // camera vectors.
    if (code == 8'h05) return 9;
    if (code == 8'h09) return 4;
    return 1;
  endfunction

  // fixed < 0 asks for random payload bytes.
  task automatic add_frame(input string name, input logic [7:0] cmd, input int n_pay,
                           input int fixed, input int bad, input int done, input logic rdy);
    frame_name[nf]     = name;
    frame_len[nf]      = n_pay + 1;
    frame_bytes[nf][0] = cmd;
    for (int j = 1; j <= n_pay; j++) begin
      rng = next_random(rng);
      frame_bytes[nf][j] = (fixed < 0) ? rng[7:0] : 8'(fixed);
    end
    bad_pos[nf]   = bad;
    exp_done[nf]  = done;
    exp_ready[nf] = rdy;
    nf++;
  endtask

  // ################################################
  // reference model of the frame rules
  // ################################################
  task automatic model_byte(input logic [7:0] b);
    if (!m_busy) begin
      if (b <= 8'h09) begin  // unknown codes are ignored.
        m_cmd  = b;
        m_left = cmd_bytes(b);
        m_pay  = '0;
        m_busy = 1'b1;
      end
    end else begin
      m_pay = {m_pay[63:0], b};
      m_left--;
      if (m_left == 0) begin
        m_busy = 1'b0;
        case (m_cmd)
          8'h00: exp_cam.origin  = m_pay[47:0];
          8'h01: exp_cam.forward = m_pay[47:0];
          8'h02: exp_cam.right   = m_pay[47:0];
          8'h03: exp_cam.up      = m_pay[47:0];
          8'h04: m_obj_ptr = m_pay[3:0];
          8'h05: begin
            exp_obj[m_obj_ptr].center.x = m_pay[71:56];
            exp_obj[m_obj_ptr].center.y = m_pay[55:40];
            exp_obj[m_obj_ptr].center.z = m_pay[39:24];
            exp_obj[m_obj_ptr].radius   = m_pay[23:8];
            exp_obj[m_obj_ptr].mat_idx  = m_pay[7:0];
          end
          8'h06: exp_num    = m_pay[7:0];
          8'h07: exp_bounce = m_pay[7:0];
          8'h08: m_mat_ptr  = m_pay[3:0];
          default: exp_mat[m_mat_ptr] = '{pad: '0, red: m_pay[31:24], green: m_pay[23:16],
                                          blue: m_pay[15:8], reflect: m_pay[7:0]};
        endcase
      end
    end
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [191:0] exp, input logic [191:0] act);
    check_count++;
    assert (exp === act) else begin
      error_count++;
      $display("Error %s: %s expected %h actual %h", test, what, exp, act);
    end
  endtask

  task automatic drive_bit(input logic v);
    @(posedge clk) rxd <= v;
    repeat (BIT_CLKS - 1) @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] b, input logic bad_stop);
    drive_bit(1'b0);
    for (int k = 0; k < 8; k++) drive_bit(b[k]);  // lsb first.
    drive_bit(!bad_stop);
    drive_bit(1'b1);
    drive_bit(1'b1);
  endtask

  task automatic check_state(input int f);
    check_value(frame_name[f], "camera", 192'(exp_cam), 192'(camera));
    check_value(frame_name[f], "num_objs", 192'(exp_num), 192'(num_objs));
    check_value(frame_name[f], "max_bounces", 192'(exp_bounce), 192'(max_bounces));
    check_value(frame_name[f], "busy", 192'(m_busy), 192'(busy));
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      obj_rd_idx <= 4'(i);
      mat_rd_idx <= 4'(i);
      @(posedge clk);
      @(negedge clk);  // read data is one cycle behind the index.
      check_value(frame_name[f], $sformatf("obj[%0d]", i), 192'(exp_obj[i]), 192'(obj_rd_data));
      check_value(frame_name[f], $sformatf("mat[%0d]", i), 192'(exp_mat[i]), 192'(mat_rd_data));
    end
    check_value(frame_name[f], "scene_ready", 192'(exp_ready[f]), 192'(scene_ready));
  endtask

  // ################################################
  // main sequence
  // ################################################
  initial begin
    int done_before;
    int waited;
    rst = 1'b1;
    rxd = 1'b1;
    obj_rd_idx = '0;
    mat_rd_idx = '0;
    exp_cam = '0;
    for (int i = 0; i < 16; i++) begin
      exp_obj[i] = '0;
      exp_mat[i] = '0;
    end
    {m_obj_ptr, m_mat_ptr, exp_num, exp_bounce, m_cmd, m_pay, m_busy} = '0;
    m_left = 0;
    add_frame("cam_origin", 8'h00, 6, -1, -1, 1, 1'b0);
    add_frame("cam_forward", 8'h01, 6, -1, -1, 1, 1'b0);
    add_frame("cam_right", 8'h02, 6, -1, -1, 1, 1'b0);
    add_frame("cam_up", 8'h03, 6, -1, -1, 1, 1'b0);
    add_frame("num_objs_2", 8'h06, 1, 2, -1, 1, 1'b0);
    add_frame("obj_idx_0", 8'h04, 1, 0, -1, 1, 1'b0);
    add_frame("obj_data_0", 8'h05, 9, -1, -1, 1, 1'b0);
    add_frame("obj_idx_1", 8'h04, 1, 1, -1, 1, 1'b0);
    add_frame("obj_data_1", 8'h05, 9, -1, -1, 1, 1'b1);
    add_frame("obj_idx_5", 8'h04, 1, 'h15, -1, 1, 1'b1);
    add_frame("obj_data_5", 8'h05, 9, -1, -1, 1, 1'b1);
    add_frame("max_bounces", 8'h07, 1, -1, -1, 1, 1'b1);
    add_frame("mat_idx_3", 8'h08, 1, 3, -1, 1, 1'b1);
    add_frame("mat_data_3", 8'h09, 4, -1, -1, 1, 1'b1);
    add_frame("unknown_cmd", 8'h2a, 0, -1, -1, 0, 1'b1);
    add_frame("num_objs_3", 8'h06, 1, 3, -1, 1, 1'b0);
    add_frame("obj_idx_2", 8'h04, 1, 2, -1, 1, 1'b0);
    add_frame("obj_data_2", 8'h05, 9, -1, -1, 1, 1'b1);
    add_frame("mat_idx_7", 8'h08, 1, 7, -1, 1, 1'b1);
    add_frame("mat_bad_stop", 8'h09, 5, -1, 2, 1, 1'b1);  // one payload byte dropped.
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      done_before = done_cnt;
      for (int j = 0; j < frame_len[f]; j++) begin
        send_byte(frame_bytes[f][j], j == bad_pos[f]);
        if (j != bad_pos[f]) model_byte(frame_bytes[f][j]);
        @(negedge clk);  // busy spans the command to the last byte.
        check_value(frame_name[f], $sformatf("busy after byte %0d", j), 192'(m_busy),
                    192'(busy));
      end
      waited = 0;
      while (done_cnt == done_before && waited < 40) begin
        @(posedge clk);
        waited++;
      end
      @(negedge clk);
      if (exp_done[f] != 0) begin
        assert (done_cnt != done_before) else begin
          error_count++;
          $display("load_done never pulsed for frame %s", frame_name[f]);
        end
      end
      check_value(frame_name[f], "load_done count", 192'(exp_done[f]),
                  192'(done_cnt - done_before));
      check_state(f);
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) $display("*** PASSED ***");
    else $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- flist.f
rt_scene_pkg.sv
uart_byte_rx.sv
scene_cmd_parser.sv
scene_store.sv
scene_output.sv
scene_loader_top.sv
tb_scene_loader.sv

//--- run.sh
#!/bin/sh
# build and run the scene loader testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --assert --top-module tb_scene_loader \
    -f flist.f -o tb_sim && ./obj_dir/tb_sim; } > sim.log 2>&1 \
  || echo "*** FAILED ***" >> sim.log
cat sim.log
grep -qF "*** FAILED ***" sim.log && { echo "simulation failed"; exit 1; } \
  || echo "simulation passed"
exit 0
